/* verilog/cpu_defines.svh */
// widths, reset pc, opcode and alu-op codes for the rv64i core; include wherever a macro is used
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath widths
`define XLEN 64
`define ILEN 32
`define REG_IDX_W 5
`define ALU_OP_W 4

// first fetch address after reset
`define PC_RESET 64'h0000_0000_8000_0000

// major opcodes, inst[6:0]
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_IMM 7'b0010011
`define OP_REG 7'b0110011
`define OP_SYSTEM 7'b1110011

// alu operation codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_SLL 4'd2
`define ALU_SLT 4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR 4'd5
`define ALU_SRL 4'd6
`define ALU_SRA 4'd7
`define ALU_OR 4'd8
`define ALU_AND 4'd9
`define ALU_EQ 4'd10
`define ALU_NE 4'd11
`define ALU_GE 4'd12
`define ALU_GEU 4'd13
`define ALU_PASSB 4'd14

`endif

/* verilog/cpu_pkg.sv */
// shared vector types of the rv64i core, referenced by scoped name from every block
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  // one register / alu / load / store word
  typedef logic [`XLEN-1:0] xdata_t;

  // byte address, used for pc and data accesses
  typedef logic [`XLEN-1:0] addr_t;

  // raw instruction word
  typedef logic [`ILEN-1:0] inst_t;

  // architectural register number
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // alu operation, see ALU_* codes
  typedef logic [`ALU_OP_W-1:0] alu_op_t;

  // one enable per byte lane of a doubleword
  typedef logic [`XLEN/8-1:0] byte_mask_t;

  // access size, 0 byte, 1 half, 2 word, 3 double
  typedef logic [1:0] size_t;

endpackage

`default_nettype wire

/* verilog/decoder.sv */
// combinational rv64i decoder; maps one instruction word to register indices, immediate and controls
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decoder (
  input  cpu_pkg::inst_t    inst,
  output cpu_pkg::reg_idx_t rd,
  output cpu_pkg::reg_idx_t rs1,
  output cpu_pkg::reg_idx_t rs2,
  output cpu_pkg::xdata_t   imm,
  output cpu_pkg::alu_op_t  alu_op,
  output logic              use_imm,
  output logic              use_pc,
  output logic              reg_wen,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_lui,
  output logic              is_ebreak,
  output logic              is_illegal,
  output logic              load_unsigned,
  output cpu_pkg::size_t    mem_size
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  cpu_pkg::xdata_t imm_i;
  cpu_pkg::xdata_t imm_s;
  cpu_pkg::xdata_t imm_b;
  cpu_pkg::xdata_t imm_u;
  cpu_pkg::xdata_t imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions in every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // immediates, all sign-extended from inst[31]
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // size and signedness straight from funct3 for loads and stores
  assign mem_size      = funct3[1:0];
  assign load_unsigned = funct3[2];

  always_comb begin
    imm        = '0;
    alu_op     = `ALU_ADD;
    use_imm    = 1'b0;
    use_pc     = 1'b0;
    reg_wen    = 1'b0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    is_branch  = 1'b0;
    is_jal     = 1'b0;
    is_jalr    = 1'b0;
    is_lui     = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      `OP_LUI: begin
        // core swaps in pass-b for lui
        {is_lui, reg_wen, use_imm} = 3'b111;
        imm = imm_u;
      end
      `OP_AUIPC: begin
        {reg_wen, use_pc, use_imm} = 3'b111;
        imm = imm_u;
      end
      `OP_JAL: begin
        // alu forms pc + imm as the target
        {is_jal, reg_wen, use_pc, use_imm} = 4'b1111;
        imm = imm_j;
      end
      `OP_JALR: begin
        {is_jalr, reg_wen, use_imm} = 3'b111;
        imm = imm_i;
        is_illegal = (funct3 != 3'b000);
      end
      `OP_BRANCH: begin
        // rs1 against rs2, target add lives in the core
        is_branch = 1'b1;
        imm = imm_b;
        case (funct3)
          3'b000:  alu_op = `ALU_EQ;
          3'b001:  alu_op = `ALU_NE;
          3'b100:  alu_op = `ALU_SLT;
          3'b101:  alu_op = `ALU_GE;
          3'b110:  alu_op = `ALU_SLTU;
          3'b111:  alu_op = `ALU_GEU;
          default: is_illegal = 1'b1;
        endcase
      end
      `OP_LOAD: begin
        {is_load, reg_wen, use_imm} = 3'b111;
        imm = imm_i;
        // no ldu in rv64i
        is_illegal = (funct3 == 3'b111);
      end
      `OP_STORE: begin
        {is_store, use_imm} = 2'b11;
        imm = imm_s;
        is_illegal = funct3[2];
      end
      `OP_IMM: begin
        {reg_wen, use_imm} = 2'b11;
        imm = imm_i;
        case (funct3)
          3'b000: alu_op = `ALU_ADD;
          3'b010: alu_op = `ALU_SLT;
          3'b011: alu_op = `ALU_SLTU;
          3'b100: alu_op = `ALU_XOR;
          3'b110: alu_op = `ALU_OR;
          3'b111: alu_op = `ALU_AND;
          // 6-bit shamt, funct6 in inst[31:26]
          3'b001: begin
            alu_op = `ALU_SLL;
            is_illegal = (inst[31:26] != 6'b000000);
          end
          default: begin
            alu_op = inst[30] ? `ALU_SRA : `ALU_SRL;
            is_illegal = ({inst[31], inst[29:26]} != 5'b00000);
          end
        endcase
      end
      `OP_REG: begin
        reg_wen = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = `ALU_ADD;
          {7'h20, 3'b000}: alu_op = `ALU_SUB;
          {7'h00, 3'b001}: alu_op = `ALU_SLL;
          {7'h00, 3'b010}: alu_op = `ALU_SLT;
          {7'h00, 3'b011}: alu_op = `ALU_SLTU;
          {7'h00, 3'b100}: alu_op = `ALU_XOR;
          {7'h00, 3'b101}: alu_op = `ALU_SRL;
          {7'h20, 3'b101}: alu_op = `ALU_SRA;
          {7'h00, 3'b110}: alu_op = `ALU_OR;
          {7'h00, 3'b111}: alu_op = `ALU_AND;
          default:         is_illegal = 1'b1;
        endcase
      end
      `OP_SYSTEM: begin
        // only the exact ebreak word is accepted
        is_ebreak  = (inst == 32'h0010_0073);
        is_illegal = (inst != 32'h0010_0073);
      end
      default: is_illegal = 1'b1;
    endcase
    // an illegal word must leave no trace in registers or memory
    if (is_illegal) begin
      reg_wen  = 1'b0;
      is_store = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu.sv */
// 64-bit alu of the core; arithmetic, logic, shifts and the compares used for slt and branches
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu (
  input  cpu_pkg::xdata_t  operand_a,
  input  cpu_pkg::xdata_t  operand_b,
  input  cpu_pkg::alu_op_t alu_op,
  output cpu_pkg::xdata_t  result
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv64 shifts use six bits of the amount
  assign shamt = operand_b[5:0];
  assign lt_s  = $signed(operand_a) < $signed(operand_b);
  assign lt_u  = operand_a < operand_b;

  always_comb begin
    case (alu_op)
      `ALU_ADD:   result = operand_a + operand_b;
      `ALU_SUB:   result = operand_a - operand_b;
      `ALU_SLL:   result = operand_a << shamt;
      `ALU_SRL:   result = operand_a >> shamt;
      `ALU_SRA:   result = $signed(operand_a) >>> shamt;
      `ALU_XOR:   result = operand_a ^ operand_b;
      `ALU_OR:    result = operand_a | operand_b;
      `ALU_AND:   result = operand_a & operand_b;
      // compares land in bit 0, doubles as branch taken
      `ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lt_s};
      `ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, lt_u};
      `ALU_EQ:    result = {{(`XLEN-1){1'b0}}, operand_a == operand_b};
      `ALU_NE:    result = {{(`XLEN-1){1'b0}}, operand_a != operand_b};
      `ALU_GE:    result = {{(`XLEN-1){1'b0}}, ~lt_s};
      `ALU_GEU:   result = {{(`XLEN-1){1'b0}}, ~lt_u};
      `ALU_PASSB: result = operand_b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
// architectural integer registers x1..x31 with two combinational read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  input  cpu_pkg::reg_idx_t rd,
  input  logic              wen,
  input  cpu_pkg::xdata_t   wdata,
  output cpu_pkg::xdata_t   rdata_1,
  output cpu_pkg::xdata_t   rdata_2
);

  // x0 has no storage
  cpu_pkg::xdata_t regs [31:1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/load_store_unit.sv */
// byte-lane steering between the core and a doubleword-wide data memory, for stores and loads
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  cpu_pkg::addr_t      addr,
  input  cpu_pkg::size_t      mem_size,
  input  logic                load_unsigned,
  input  logic                is_store,
  input  cpu_pkg::xdata_t     store_data,
  input  cpu_pkg::xdata_t     mem_rdata,
  output cpu_pkg::byte_mask_t wmask,
  output cpu_pkg::xdata_t     wdata,
  output cpu_pkg::xdata_t     load_data
);

  logic [2:0]          offset;
  logic [5:0]          bit_shift;
  cpu_pkg::byte_mask_t size_mask;
  cpu_pkg::xdata_t     rd_shifted;
  logic                ext_bit;

  // byte position inside the doubleword
  assign offset    = addr[2:0];
  assign bit_shift = {offset, 3'b000};

  // lanes covered by an access at offset 0
  always_comb begin
    case (mem_size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // aligned accesses only, so the shift never wraps
  assign wmask = is_store ? (size_mask << offset) : '0;
  assign wdata = store_data << bit_shift;

  // move the addressed bytes down to lane 0
  assign rd_shifted = mem_rdata >> bit_shift;

  always_comb begin
    case (mem_size)
      2'd0:    ext_bit = rd_shifted[7] & ~load_unsigned;
      2'd1:    ext_bit = rd_shifted[15] & ~load_unsigned;
      default: ext_bit = rd_shifted[31] & ~load_unsigned;
    endcase
    case (mem_size)
      2'd0:    load_data = {{56{ext_bit}}, rd_shifted[7:0]};
      2'd1:    load_data = {{48{ext_bit}}, rd_shifted[15:0]};
      2'd2:    load_data = {{32{ext_bit}}, rd_shifted[31:0]};
      // ld needs no extension
      default: load_data = rd_shifted;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
// single-cycle rv64i core top; fetches, executes and retires one instruction per clock
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
  input  logic                clk,
  input  logic                rst_n,
  output cpu_pkg::addr_t      imem_addr,
  input  cpu_pkg::inst_t      imem_rdata,
  output cpu_pkg::addr_t      dmem_addr,
  output logic                dmem_wen,
  output cpu_pkg::byte_mask_t dmem_wmask,
  output cpu_pkg::xdata_t     dmem_wdata,
  input  cpu_pkg::xdata_t     dmem_rdata,
  output logic                halted,
  output logic                illegal
);

  cpu_pkg::addr_t    pc_q;
  logic              halted_q;
  logic              illegal_q;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::reg_idx_t rs1;
  cpu_pkg::reg_idx_t rs2;
  cpu_pkg::xdata_t   imm;
  cpu_pkg::alu_op_t  dec_alu_op;
  cpu_pkg::alu_op_t  alu_op;
  logic              use_imm;
  logic              use_pc;
  logic              reg_wen;
  logic              is_load;
  logic              is_store;
  logic              is_branch;
  logic              is_jal;
  logic              is_jalr;
  logic              is_lui;
  logic              is_ebreak;
  logic              is_illegal;
  logic              load_unsigned;
  cpu_pkg::size_t    mem_size;
  cpu_pkg::xdata_t   rdata_1;
  cpu_pkg::xdata_t   rdata_2;
  cpu_pkg::xdata_t   operand_a;
  cpu_pkg::xdata_t   operand_b;
  cpu_pkg::xdata_t   alu_result;
  cpu_pkg::xdata_t   load_data;
  cpu_pkg::xdata_t   wb_data;
  cpu_pkg::addr_t    pc_plus4;
  cpu_pkg::addr_t    branch_target;
  cpu_pkg::addr_t    next_pc;
  logic              store_en;

  assign imem_addr = pc_q;
  assign halted    = halted_q;
  assign illegal   = illegal_q;

  decoder decoder_i (
    .inst(imem_rdata), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .alu_op(dec_alu_op),
    .use_imm(use_imm), .use_pc(use_pc), .reg_wen(reg_wen), .is_load(is_load),
    .is_store(is_store), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_lui(is_lui), .is_ebreak(is_ebreak), .is_illegal(is_illegal),
    .load_unsigned(load_unsigned), .mem_size(mem_size)
  );

  // no register write once halted
  register_file register_file_i (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wen(reg_wen & ~halted_q), .wdata(wb_data), .rdata_1(rdata_1), .rdata_2(rdata_2)
  );

  // operand muxes, lui passes the upper immediate
  assign operand_a = use_pc ? pc_q : rdata_1;
  assign operand_b = use_imm ? imm : rdata_2;
  assign alu_op    = is_lui ? `ALU_PASSB : dec_alu_op;

  alu alu_i (.operand_a(operand_a), .operand_b(operand_b), .alu_op(alu_op), .result(alu_result));

  // writes are held off in reset and after halt
  assign store_en  = is_store & ~halted_q & rst_n;
  assign dmem_addr = alu_result;
  assign dmem_wen  = store_en;

  load_store_unit load_store_unit_i (
    .addr(alu_result), .mem_size(mem_size), .load_unsigned(load_unsigned),
    .is_store(store_en), .store_data(rdata_2), .mem_rdata(dmem_rdata),
    .wmask(dmem_wmask), .wdata(dmem_wdata), .load_data(load_data)
  );

  // link value for jumps, else load or alu
  assign pc_plus4 = pc_q + 64'd4;
  assign wb_data  = (is_jal | is_jalr) ? pc_plus4 : (is_load ? load_data : alu_result);

  // alu is busy comparing, so the branch target gets its own adder
  assign branch_target = pc_q + imm;
  assign next_pc = (is_jal | is_jalr) ? {alu_result[`XLEN-1:1], 1'b0} :
                   (is_branch & alu_result[0]) ? branch_target : pc_plus4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q      <= `PC_RESET;
      halted_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else if (!halted_q) begin
      // pc stays on the ebreak or illegal word that stopped the core
      if (is_ebreak | is_illegal) begin
        halted_q  <= 1'b1;
        illegal_q <= is_illegal;
      end else begin
        pc_q <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/cpu_core_props.sv */
// assertions on store enable, store byte mask and halt flag of the core; attached to cpu_core by bind
`timescale 1ns/1ps
`default_nettype none

module cpu_core_props (
  input logic                clk,
  input logic                rst_n,
  input logic                dmem_wen,
  input cpu_pkg::byte_mask_t dmem_wmask,
  input logic                halted
);

  cpu_pkg::byte_mask_t low_bit;
  logic                one_run;
  logic                legal_count;
  int                  assert_failures = 0;

  // lowest set lane of the mask
  assign low_bit = dmem_wmask & (~dmem_wmask + 8'd1);
  // adding the lowest bit clears a single run of ones
  assign one_run = ((dmem_wmask + low_bit) & dmem_wmask) == 8'd0;
  assign legal_count = ($countones(dmem_wmask) == 1) || ($countones(dmem_wmask) == 2) ||
                       ($countones(dmem_wmask) == 4) || ($countones(dmem_wmask) == 8);

  // no memory write in reset or after halt
  no_store_when_stopped: assert property (@(posedge clk) (!rst_n || halted) |-> !dmem_wen)
    else begin
      assert_failures++;
      $error("store enable high during reset or while halted");
    end

  // halt is sticky until reset
  halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else begin
      assert_failures++;
      $error("halted dropped without reset");
    end

  // byte, half, word or double lanes, one block
  store_mask_shape: assert property (@(posedge clk) dmem_wen |-> (one_run && legal_count))
    else begin
      assert_failures++;
      $error("store byte mask %b is not one run of 1, 2, 4 or 8 lanes", dmem_wmask);
    end

endmodule

`default_nettype wire

/* verification/cpu_core_checker.sv */
// isa reference model of the core; replays the testbench program and compares fetches, stores, halt
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_checker (
  input logic                clk,
  input logic                rst_n,
  input cpu_pkg::addr_t      imem_addr,
  input cpu_pkg::addr_t      dmem_addr,
  input logic                dmem_wen,
  input cpu_pkg::byte_mask_t dmem_wmask,
  input cpu_pkg::xdata_t     dmem_wdata,
  input logic                halted,
  input logic                illegal
);

  localparam cpu_pkg::inst_t EBREAK = 32'h0010_0073;

  // model state
  cpu_pkg::xdata_t regs [0:31];
  cpu_pkg::xdata_t mem [0:31];
  cpu_pkg::addr_t  pc;
  logic            m_halted;
  logic            m_illegal;
  int              error_count = 0;

  task automatic report(input string msg);
    error_count++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // words outside the image read as zero
  function automatic cpu_pkg::inst_t fetch(input cpu_pkg::addr_t a);
    cpu_pkg::addr_t off;
    off = a - `PC_RESET;
    if (off >= 64'd1024) begin
      return '0;
    end
    return cpu_core_tb.imem[off[9:2]];
  endfunction

  // integer ops by funct3, alt picks sub / sra
  function automatic cpu_pkg::xdata_t alu_model(input logic [2:0] f3, input cpu_pkg::xdata_t x,
                                                input cpu_pkg::xdata_t y, input logic alt);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[5:0];
      3'd2: return {63'd0, $signed(x) < $signed(y)};
      3'd3: return {63'd0, x < y};
      3'd4: return x ^ y;
      3'd5: begin
        if (alt) begin
          return $signed(x) >>> y[5:0];
        end
        return x >> y[5:0];
      end
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic reset_model();
    pc        = `PC_RESET;
    m_halted  = 1'b0;
    m_illegal = 1'b0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
      mem[r]  = cpu_core_tb.dmem[r];
    end
  endtask

  // one instruction, compared against this cycle's outputs
  task automatic retire_model();
    cpu_pkg::inst_t      w;
    logic [2:0]          f3;
    cpu_pkg::xdata_t     a;
    cpu_pkg::xdata_t     b;
    cpu_pkg::xdata_t     imm_i;
    cpu_pkg::xdata_t     res;
    cpu_pkg::xdata_t     dw;
    cpu_pkg::addr_t      ea;
    cpu_pkg::addr_t      nxt;
    cpu_pkg::byte_mask_t exp_mask;
    logic                wr;
    logic                taken;
    int                  nbytes;
    int                  off;
    w     = fetch(pc);
    f3    = w[14:12];
    a     = regs[w[19:15]];
    b     = regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    nxt   = pc + 64'd4;
    wr    = 1'b0;
    res   = '0;
    if (dmem_wen !== 1'b0 && w[6:0] != `OP_STORE) begin
      report($sformatf("store enable set by non-store word %h at pc %h", w, pc));
    end
    case (w[6:0])
      `OP_LUI: begin
        res = {{32{w[31]}}, w[31:12], 12'h000};
        wr  = 1'b1;
      end
      `OP_AUIPC: begin
        res = pc + {{32{w[31]}}, w[31:12], 12'h000};
        wr  = 1'b1;
      end
      `OP_JAL: begin
        res = pc + 64'd4;
        wr  = 1'b1;
        nxt = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      `OP_JALR: begin
        res = pc + 64'd4;
        wr  = 1'b1;
        nxt = (a + imm_i) & ~64'd1;
      end
      `OP_BRANCH: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) begin
          nxt = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      `OP_LOAD: begin
        ea = a + imm_i;
        // addressed bytes down to lane 0
        dw = mem[ea[7:3]] >> {ea[2:0], 3'b000};
        wr = 1'b1;
        case (f3)
          3'd0: res = {{56{dw[7]}}, dw[7:0]};
          3'd1: res = {{48{dw[15]}}, dw[15:0]};
          3'd2: res = {{32{dw[31]}}, dw[31:0]};
          3'd4: res = {56'd0, dw[7:0]};
          3'd5: res = {48'd0, dw[15:0]};
          3'd6: res = {32'd0, dw[31:0]};
          default: res = dw;
        endcase
      end
      `OP_STORE: begin
        ea       = a + {{52{w[31]}}, w[31:25], w[11:7]};
        nbytes   = 1 << f3[1:0];
        off      = ea[2:0];
        exp_mask = '0;
        for (int j = 0; j < nbytes; j++) begin
          exp_mask[off + j] = 1'b1;
        end
        if (dmem_wen !== 1'b1) begin
          report($sformatf("no store enable for store at pc %h", pc));
        end
        if (dmem_addr !== ea || dmem_wmask !== exp_mask) begin
          report($sformatf("store addr %h mask %b, expected %h mask %b",
                           dmem_addr, dmem_wmask, ea, exp_mask));
        end
        // byte j of rs2 lands in lane off + j
        for (int j = 0; j < nbytes; j++) begin
          if (dmem_wdata[8*(off+j) +: 8] !== b[8*j +: 8]) begin
            report($sformatf("store lane %0d is %h, expected %h at pc %h",
                             off + j, dmem_wdata[8*(off+j) +: 8], b[8*j +: 8], pc));
          end
          mem[ea[7:3]][8*(off+j) +: 8] = b[8*j +: 8];
        end
      end
      `OP_IMM: begin
        res = alu_model(f3, a, imm_i, w[30] && (f3 == 3'd5));
        wr  = 1'b1;
      end
      `OP_REG: begin
        res = alu_model(f3, a, b, w[30]);
        wr  = 1'b1;
      end
      default: begin
        // ebreak or an undefined word, pc stays on it
        m_halted  = 1'b1;
        m_illegal = (w != EBREAK);
        nxt       = pc;
      end
    endcase
    if (wr && w[11:7] != 5'd0) begin
      regs[w[11:7]] = res;
    end
    pc = nxt;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      if (halted !== m_halted || illegal !== m_illegal) begin
        report($sformatf("halted %b illegal %b, expected %b %b",
                         halted, illegal, m_halted, m_illegal));
      end
      if (imem_addr !== pc) begin
        report($sformatf("fetch address %h, expected %h", imem_addr, pc));
      end
      if (m_halted) begin
        if (dmem_wen !== 1'b0) begin
          report("store enable set while halted");
        end
      end else begin
        retire_model();
      end
    end
  end

endmodule

`default_nettype wire

/* verification/cpu_core_tb.sv */
// top testbench of the core; memories, random programs, reset and the final verdict
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_tb;

  localparam int             BODY_LEN   = 200;
  localparam int             PROG_LEN   = BODY_LEN + 2;
  localparam int             IMEM_WORDS = 256;
  localparam int             DMEM_WORDS = 32;
  localparam cpu_pkg::addr_t DATA_BASE  = 64'h0000_0000_0000_1000;

  logic                clk;
  logic                rst_n;
  cpu_pkg::addr_t      imem_addr;
  cpu_pkg::inst_t      imem_rdata;
  cpu_pkg::addr_t      imem_off;
  cpu_pkg::addr_t      dmem_addr;
  logic                dmem_wen;
  cpu_pkg::byte_mask_t dmem_wmask;
  cpu_pkg::xdata_t     dmem_wdata;
  cpu_pkg::xdata_t     dmem_rdata;
  logic                halted;
  logic                illegal;
  cpu_pkg::inst_t      imem [0:IMEM_WORDS-1];
  cpu_pkg::xdata_t     dmem [0:DMEM_WORDS-1];
  int                  seed;
  int                  tb_errors   = 0;
  int                  cycle_count = 0;
  int                  cycle_limit = 2 * (PROG_LEN + 10);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // combinational memories, 256-byte data window
  assign imem_off   = imem_addr - `PC_RESET;
  assign imem_rdata = (imem_off < 64'd1024) ? imem[imem_off[9:2]] : '0;
  assign dmem_rdata = dmem[dmem_addr[7:3]];

  always @(posedge clk) begin
    if (dmem_wen) begin
      for (int k = 0; k < 8; k++) begin
        if (dmem_wmask[k]) begin
          dmem[dmem_addr[7:3]][8*k +: 8] <= dmem_wdata[8*k +: 8];
        end
      end
    end
  end

  cpu_core cpu_core_i (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wen(dmem_wen), .dmem_wmask(dmem_wmask),
    .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .halted(halted), .illegal(illegal)
  );

  cpu_core_checker cpu_core_checker_i (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
    .dmem_wen(dmem_wen), .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
    .halted(halted), .illegal(illegal)
  );

  bind cpu_core cpu_core_props cpu_core_props_i (
    .clk(clk), .rst_n(rst_n), .dmem_wen(dmem_wen), .dmem_wmask(dmem_wmask), .halted(halted)
  );

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // mixes every address bit, sign bits vary
  function automatic cpu_pkg::xdata_t fill_word(input cpu_pkg::addr_t addr);
    return addr * 64'h9e37_79b9_7f4a_7c15 ^ {addr[31:0], ~addr[31:0]};
  endfunction

  task automatic build_program(input logic end_illegal);
    int                i;
    int                k;
    int                kind;
    int                span;
    logic [31:0]       word;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic [11:0]       off12;
    logic [12:0]       boff;
    logic [20:0]       joff;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rx;
    logic              jump_target [0:IMEM_WORDS-1];
    for (int a = 0; a < IMEM_WORDS; a++) begin
      imem[a]        = '0;
      jump_target[a] = 1'b0;
    end
    for (int a = 0; a < DMEM_WORDS; a++) begin
      dmem[a] = fill_word(DATA_BASE + cpu_pkg::addr_t'(a * 8));
    end
    // prologue, x31 holds the data base
    imem[0] = {DATA_BASE[31:12], 5'd31, `OP_LUI};
    i = 1;
    while (i <= BODY_LEN) begin
      word = $random(seed);
      kind = rnd(9);
      // rd never x31
      rd   = cpu_pkg::reg_idx_t'(rnd(31));
      f3   = word[14:12];
      span = (BODY_LEN + 1 - i < 6) ? BODY_LEN + 1 - i : 6;
      k    = 1 + rnd(span);
      // aligned offset inside the data window
      off12 = {4'd0, word[27:20]};
      case (kind)
        0: imem[i] = {word[31:12], rd, `OP_LUI};
        1: imem[i] = {word[31:12], rd, `OP_AUIPC};
        2: begin
          off12 = word[31:20];
          // shifts keep a legal funct6
          if (f3 == 3'd1) begin
            off12[11:6] = 6'd0;
          end
          if (f3 == 3'd5) begin
            off12[11:6] = {1'b0, word[30], 4'd0};
          end
          imem[i] = {off12, word[19:15], f3, rd, `OP_IMM};
        end
        3: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && word[30]) ? 7'h20 : 7'h00;
          imem[i] = {f7, word[24:20], word[19:15], f3, rd, `OP_REG};
        end
        4: begin
          // lb lh lw ld lbu lhu lwu
          f3 = word[2:0] % 3'd7;
          off12 = off12 & ~((12'd1 << f3[1:0]) - 12'd1);
          imem[i] = {off12, 5'd31, f3, rd, `OP_LOAD};
        end
        5: begin
          f3 = {1'b0, word[1:0]};
          off12 = off12 & ~((12'd1 << f3[1:0]) - 12'd1);
          imem[i] = {off12[11:5], word[24:20], 5'd31, f3, off12[4:0], `OP_STORE};
        end
        6: begin
          // funct3 2 and 3 fold onto beq and bne
          if (f3[2:1] == 2'b01) begin
            f3[1] = 1'b0;
          end
          boff = {k[10:0], 2'b00};
          imem[i] = {boff[12], boff[10:5], word[24:20], word[19:15], f3, boff[4:1],
                     boff[11], `OP_BRANCH};
          jump_target[i + k] = 1'b1;
        end
        7: begin
          joff = {k[18:0], 2'b00};
          imem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `OP_JAL};
          jump_target[i + k] = 1'b1;
        end
        default: begin
          // a jalr entered past its auipc would see a stale base
          if (i < BODY_LEN && !jump_target[i + 1]) begin
            // auipc then jalr forward from it
            rx = 5'd1 + cpu_pkg::reg_idx_t'(rnd(30));
            imem[i] = {20'd0, rx, `OP_AUIPC};
            i++;
            span = (BODY_LEN + 1 - i < 6) ? BODY_LEN + 1 - i : 6;
            k = 1 + rnd(span);
            // odd target now and then, bit 0 is dropped
            off12 = {1'b0, k[8:0], 2'b00} + 12'd4 + {11'd0, word[0]};
            imem[i] = {off12, rx, 3'b000, rd, `OP_JALR};
            jump_target[i + k] = 1'b1;
          end else begin
            imem[i] = {12'd0, 5'd0, 3'b000, 5'd0, `OP_IMM};
          end
        end
      endcase
      i++;
    end
    // custom-0 opcode is undefined here
    imem[BODY_LEN + 1] = end_illegal ? {word[31:12], 5'd7, 7'b0001011} : 32'h0010_0073;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    cycle_count = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // halt, then a few idle cycles for the checker
  task automatic finish_program(input logic expect_illegal);
    wait (halted === 1'b1);
    repeat (4) @(negedge clk);
    if (halted !== 1'b1 || illegal !== expect_illegal) begin
      tb_errors++;
      $display("CHECK FAILED at %0t: halted %b illegal %b after halt, expected 1 %b",
               $time, halted, illegal, expect_illegal);
    end
  endtask

  // watchdog, limit per program
  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: core did not halt within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

  initial begin
    int total;
    rst_n = 1'b0;
    seed  = 46882;
    build_program(1'b0);
    apply_reset();
    finish_program(1'b0);
    build_program(1'b1);
    apply_reset();
    finish_program(1'b1);
    total = cpu_core_checker_i.error_count + tb_errors +
            cpu_core_i.cpu_core_props_i.assert_failures;
    $display("errors: checker %0d, testbench %0d, assertions %0d",
             cpu_core_checker_i.error_count, tb_errors,
             cpu_core_i.cpu_core_props_i.assert_failures);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/alu.sv
verilog/register_file.sv
verilog/load_store_unit.sv
verilog/cpu_core.sv
verification/cpu_core_props.sv
verification/cpu_core_checker.sv
verification/cpu_core_tb.sv
